// File: list.f
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_alu.sv
verilog/lc4_regfile_2w.sv
verilog/lc4_issue_ctrl.sv
verilog/lc4_bypass.sv
verilog/lc4_superscalar.sv
verification/lc4_superscalar_asserts.sv
verification/tb_lc4_superscalar.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_lc4_superscalar -f list.f
	./obj_dir/Vtb_lc4_superscalar

clean:
	rm -rf obj_dir

// File: verification/tb_lc4_superscalar.sv
`timescale 1ns/100ps

module tb_lc4_superscalar;
    import lc4_pkg::*;

    localparam int NUM_ROWS = 5;
    localparam int PROG_LEN = 12;
    localparam int MAX_ST = 4;
    localparam int RUN_CYCLES = 40;
    localparam int LIMIT = NUM_ROWS * 80;

    logic gwe, i_arst_n;
    logic [DATA_W-1:0] o_cur_pc, i_insn_a, i_insn_b;
    logic [DATA_W-1:0] o_dmem_addr, o_dmem_towrite, i_dmem_data;
    logic o_dmem_we, o_wb_we_a, o_wb_we_b;
    logic [SEL_W-1:0] o_wb_sel_a, o_wb_sel_b;
    logic [DATA_W-1:0] o_wb_data_a, o_wb_data_b;

    // test table
    string       names [NUM_ROWS];
    logic [15:0] progs [NUM_ROWS][PROG_LEN];
    logic [15:0] exp_regs [NUM_ROWS][NUM_REGS];
    // regs whose expected value also adds the seeded word at ld_addr
    logic [7:0]  ld_mask [NUM_ROWS];
    logic [7:0]  ld_addr [NUM_ROWS];
    int          st_cnt [NUM_ROWS];
    logic [15:0] st_addr [NUM_ROWS][MAX_ST];
    logic [15:0] st_data [NUM_ROWS][MAX_ST];

    logic [15:0] imem [PROG_LEN];
    logic [15:0] seed_mem [256];
    logic [15:0] dmem [256];
    logic [15:0] shadow [NUM_REGS];
    logic [15:0] got_addr [$];
    logic [15:0] got_data [$];
    integer      seed;
    int          cycles;
    logic [15:0] pc_off_a, pc_off_b;

    lc4_superscalar dut_i (.*);

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // instruction memory padded with zero words that decode as no-ops
    always_comb begin
        pc_off_a = o_cur_pc - PC_RESET;
        pc_off_b = pc_off_a + 16'd1;
        i_insn_a = (pc_off_a < 16'(PROG_LEN)) ? imem[pc_off_a[3:0]] : 16'h0000;
        i_insn_b = (pc_off_b < 16'(PROG_LEN)) ? imem[pc_off_b[3:0]] : 16'h0000;
    end

    // data memory reloaded from the seed image during reset
    assign i_dmem_data = dmem[o_dmem_addr[7:0]];
    always @(posedge gwe) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= seed_mem[i];
            end
        end else if (o_dmem_we) begin
            dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
        end
    end

    // shadow regfile and store log sampled mid-cycle in program order
    always @(negedge gwe) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] = '0;
            end
            got_addr.delete();
            got_data.delete();
        end else begin
            if (o_wb_we_a) shadow[o_wb_sel_a] = o_wb_data_a;
            if (o_wb_we_b) shadow[o_wb_sel_b] = o_wb_data_b;
            if (o_dmem_we) begin
                got_addr.push_back(o_dmem_addr);
                got_data.push_back(o_dmem_towrite);
            end
        end
    end

    // run limit
    always @(posedge gwe) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", LIMIT);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // LC4 encodings
    function automatic logic [15:0] const_op(input int rd, input logic [8:0] imm);
        return {4'b1001, 3'(rd), imm};
    endfunction
    function automatic logic [15:0] add_imm(input int rd, input int rs, input logic [4:0] imm);
        return {4'b0001, 3'(rd), 3'(rs), 1'b1, imm};
    endfunction
    function automatic logic [15:0] and_imm(input int rd, input int rs, input logic [4:0] imm);
        return {4'b0101, 3'(rd), 3'(rs), 1'b1, imm};
    endfunction
    function automatic logic [15:0] reg_op(input logic [3:0] op, input logic [2:0] sub,
                                           input int rd, input int rs, input int rt);
        return {op, 3'(rd), 3'(rs), sub, 3'(rt)};
    endfunction
    function automatic logic [15:0] mem_op(input logic [3:0] op, input int r, input int base,
                                           input logic [5:0] imm);
        return {op, 3'(r), 3'(base), imm};
    endfunction

    task automatic set_regs(input int row, input logic [15:0] r1, input logic [15:0] r2,
                            input logic [15:0] r3, input logic [15:0] r4,
                            input logic [15:0] r5, input logic [15:0] r6);
        exp_regs[row] = '{16'h0, r1, r2, r3, r4, r5, r6, 16'h0};
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            ld_mask[r] = '0;
            ld_addr[r] = '0;
            st_cnt[r] = 0;
        end
        // independent pairs
        names[0] = "independent";
        progs[0] = '{0: const_op(1, 9'd5), 1: const_op(2, 9'h1fd),
                     2: add_imm(3, 1, 5'd4), 3: and_imm(4, 2, 5'd6),
                     4: reg_op(OP_LOGIC, 3'b000, 5, 1, 2), 5: const_op(6, 9'd100),
                     default: 16'h0000};
        set_regs(0, 16'h0005, 16'hfffd, 16'h0009, 16'h0004, 16'h0005, 16'h0064);
        // B reads A inside a pair
        names[1] = "raw_in_pair";
        progs[1] = '{0: const_op(1, 9'd10), 1: add_imm(2, 1, 5'd3),
                     2: reg_op(OP_ARITH, 3'b000, 3, 2, 1),
                     3: reg_op(OP_ARITH, 3'b010, 4, 3, 2),
                     default: 16'h0000};
        set_regs(1, 16'h000a, 16'h000d, 16'h0017, 16'h000a, 16'h0000, 16'h0000);
        // MX and WX chains
        names[2] = "bypass_chain";
        progs[2] = '{0: const_op(1, 9'd1), 1: const_op(2, 9'd2),
                     2: reg_op(OP_ARITH, 3'b000, 3, 1, 2),
                     3: reg_op(OP_ARITH, 3'b000, 4, 3, 3),
                     4: reg_op(OP_ARITH, 3'b010, 5, 4, 1),
                     5: reg_op(OP_ARITH, 3'b000, 6, 5, 3),
                     default: 16'h0000};
        set_regs(2, 16'h0001, 16'h0002, 16'h0003, 16'h0006, 16'h0005, 16'h0008);
        // load then immediate use where r2..r4 add the word at address 5
        names[3] = "load_use";
        progs[3] = '{0: const_op(1, 9'd4), 1: mem_op(OP_LDR, 2, 1, 6'd1),
                     2: add_imm(3, 2, 5'd1), 3: reg_op(OP_ARITH, 3'b000, 4, 2, 1),
                     default: 16'h0000};
        set_regs(3, 16'h0004, 16'h0000, 16'h0001, 16'h0004, 16'h0000, 16'h0000);
        ld_mask[3] = 8'b0001_1100;
        ld_addr[3] = 8'd5;
        // store of A's fresh result followed by two memory ops in one pair
        names[4] = "mem_pair";
        progs[4] = '{0: const_op(1, 9'd7), 1: const_op(2, 9'd3),
                     2: add_imm(1, 1, 5'd2), 3: mem_op(OP_STR, 1, 2, 6'd0),
                     4: mem_op(OP_STR, 2, 2, 6'd1), 5: mem_op(OP_LDR, 3, 2, 6'd0),
                     default: 16'h0000};
        set_regs(4, 16'h0009, 16'h0003, 16'h0009, 16'h0000, 16'h0000, 16'h0000);
        st_cnt[4] = 2;
        st_addr[4][0] = 16'h0003;
        st_data[4][0] = 16'h0009;
        st_addr[4][1] = 16'h0004;
        st_data[4][1] = 16'h0003;
    endtask

    initial begin
        logic [15:0] exp;
        i_arst_n = 1'b0;
        cycles = 0;
        seed = 95;
        for (int i = 0; i < 256; i++) begin
            seed_mem[i] = 16'($random(seed));
        end
        for (int i = 0; i < PROG_LEN; i++) imem[i] = 16'h0000;
        build_table();

        for (int row = 0; row < NUM_ROWS; row++) begin
            @(negedge gwe);
            i_arst_n = 1'b0;
            for (int i = 0; i < PROG_LEN; i++) imem[i] = progs[row][i];
            repeat (16) @(negedge gwe);
            // fetch and write ports seen at the end of reset
            check($sformatf("%s reset pc", names[row]), PC_RESET, o_cur_pc);
            check($sformatf("%s reset dmem we", names[row]), 16'h0000, 16'(o_dmem_we));
            check($sformatf("%s reset wb we", names[row]), 16'h0000,
                  16'({o_wb_we_a, o_wb_we_b}));
            i_arst_n = 1'b1;
            repeat (RUN_CYCLES) @(negedge gwe);

            for (int r = 0; r < NUM_REGS; r++) begin
                exp = exp_regs[row][r];
                if (ld_mask[row][r]) exp = exp + seed_mem[ld_addr[row]];
                check($sformatf("%s r%0d", names[row], r), exp, shadow[r]);
            end
            check($sformatf("%s store count", names[row]), 16'(st_cnt[row]),
                  16'(got_addr.size()));
            for (int s = 0; s < st_cnt[row]; s++) begin
                check($sformatf("%s store%0d addr", names[row], s), st_addr[row][s], got_addr[s]);
                check($sformatf("%s store%0d data", names[row], s), st_data[row][s], got_data[s]);
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: verification/lc4_superscalar_asserts.sv
`timescale 1ns/100ps

module lc4_superscalar_asserts (
    input logic                        gwe,
    input logic                        i_arst_n,
    input logic [lc4_pkg::DATA_W-1:0] o_cur_pc,
    input logic                        o_dmem_we,
    input lc4_pkg::lc4_dec_t           m_a,
    input lc4_pkg::lc4_dec_t           m_b,
    input logic                        o_wb_we_a,
    input logic                        o_wb_we_b
);
    import lc4_pkg::*;

    // fetch moves by a full pair, a single word on a switch, or holds
    pc_step: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (o_cur_pc - $past(o_cur_pc)) <= DATA_W'(2))
        else $error("pc moved by more than two words");

    // only one store may own the memory port
    one_store: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> (m_a.is_store ^ m_b.is_store))
        else $error("memory write without exactly one store in M");

    // no register writes while held in reset
    wb_quiet: assert property (@(posedge gwe)
        !i_arst_n |-> (!o_wb_we_a && !o_wb_we_b))
        else $error("writeback enable high during reset");

endmodule

bind lc4_superscalar lc4_superscalar_asserts asserts_i (
    .gwe(gwe), .i_arst_n(i_arst_n), .o_cur_pc(o_cur_pc), .o_dmem_we(o_dmem_we),
    .m_a(m_a), .m_b(m_b), .o_wb_we_a(o_wb_we_a), .o_wb_we_b(o_wb_we_b)
);

// File: verilog/lc4_superscalar.sv
`timescale 1ns/100ps

module lc4_superscalar (
    input  logic                        gwe,
    input  logic                        i_arst_n,
    output logic [lc4_pkg::DATA_W-1:0] o_cur_pc,
    input  logic [lc4_pkg::DATA_W-1:0] i_insn_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_insn_b,
    output logic [lc4_pkg::DATA_W-1:0] o_dmem_addr,
    output logic                        o_dmem_we,
    output logic [lc4_pkg::DATA_W-1:0] o_dmem_towrite,
    input  logic [lc4_pkg::DATA_W-1:0] i_dmem_data,
    output logic                        o_wb_we_a,
    output logic [lc4_pkg::SEL_W-1:0]  o_wb_sel_a,
    output logic [lc4_pkg::DATA_W-1:0] o_wb_data_a,
    output logic                        o_wb_we_b,
    output logic [lc4_pkg::SEL_W-1:0]  o_wb_sel_b,
    output logic [lc4_pkg::DATA_W-1:0] o_wb_data_b
);
    import lc4_pkg::*;

    // fetch and decode
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pc_next;
    logic [DATA_W-1:0] d_insn_a;
    logic [DATA_W-1:0] d_insn_b;
    logic [DATA_W-1:0] d_next_a;
    logic [DATA_W-1:0] d_next_b;
    lc4_dec_t          d_a;
    lc4_dec_t          d_b;
    logic              issue_switch;
    logic              stall_a;
    logic              stall_b;
    logic [DATA_W-1:0] rs_d_a, rt_d_a, rs_d_b, rt_d_b;

    // execute
    lc4_dec_t          x_a;
    lc4_dec_t          x_b;
    logic [DATA_W-1:0] rs_x_a, rt_x_a, rs_x_b, rt_x_b;
    logic [DATA_W-1:0] rs_fwd_a, rt_fwd_a, rs_fwd_b, rt_fwd_b;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;

    // memory
    lc4_dec_t          m_a;
    lc4_dec_t          m_b;
    logic [DATA_W-1:0] m_res_a, m_res_b, mst_a, mst_b, st_a, st_b;
    logic              m_mem_a;
    logic              m_mem_b;

    // writeback
    lc4_dec_t          w_a;
    lc4_dec_t          w_b;
    logic [DATA_W-1:0] w_res_a, w_res_b, w_ld_a, w_ld_b, wb_a, wb_b;

    lc4_decoder u_dec_a (.i_insn(d_insn_a), .o_dec(d_a));
    lc4_decoder u_dec_b (.i_insn(d_insn_b), .o_dec(d_b));

    // W writes through to the D reads in the same cycle
    lc4_regfile_2w u_regfile (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs_sel_a(d_a.rs), .i_rt_sel_a(d_a.rt), .i_rs_sel_b(d_b.rs), .i_rt_sel_b(d_b.rt),
        .o_rs_data_a(rs_d_a), .o_rt_data_a(rt_d_a),
        .o_rs_data_b(rs_d_b), .o_rt_data_b(rt_d_b),
        .i_rd_sel_a(w_a.rd), .i_rd_we_a(w_a.rd_we), .i_wdata_a(wb_a),
        .i_rd_sel_b(w_b.rd), .i_rd_we_b(w_b.rd_we), .i_wdata_b(wb_b)
    );

    lc4_issue_ctrl u_issue (
        .i_d_a(d_a), .i_d_b(d_b), .i_x_a(x_a), .i_x_b(x_b),
        .o_switch(issue_switch), .o_stall_a(stall_a), .o_stall_b(stall_b)
    );

    lc4_bypass u_bypass (
        .i_x_a(x_a), .i_x_b(x_b), .i_m_a(m_a), .i_m_b(m_b), .i_w_a(w_a), .i_w_b(w_b),
        .i_rs_x_a(rs_x_a), .i_rt_x_a(rt_x_a), .i_rs_x_b(rs_x_b), .i_rt_x_b(rt_x_b),
        .i_m_res_a(m_res_a), .i_m_res_b(m_res_b), .i_wb_a(wb_a), .i_wb_b(wb_b),
        .i_mst_a(mst_a), .i_mst_b(mst_b),
        .o_rs_a(rs_fwd_a), .o_rt_a(rt_fwd_a), .o_rs_b(rs_fwd_b), .o_rt_b(rt_fwd_b),
        .o_st_a(st_a), .o_st_b(st_b)
    );

    lc4_alu u_alu_a (.i_insn(x_a.insn), .i_rs_data(rs_fwd_a), .i_rt_data(rt_fwd_a), .o_result(alu_a));
    lc4_alu u_alu_b (.i_insn(x_b.insn), .i_rs_data(rs_fwd_b), .i_rt_data(rt_fwd_b), .o_result(alu_b));

    // pc step and decode refill: hold, switch or full pair
    always_comb begin
        if (stall_a) begin
            pc_next = pc;
            d_next_a = d_insn_a;
            d_next_b = d_insn_b;
        end else if (issue_switch) begin
            // old B becomes A, the word at pc fills B
            pc_next = pc + DATA_W'(1);
            d_next_a = d_insn_b;
            d_next_b = i_insn_a;
        end else begin
            pc_next = pc + DATA_W'(2);
            d_next_a = i_insn_a;
            d_next_b = i_insn_b;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= PC_RESET;
            // zero insn decodes as a no-op
            d_insn_a <= '0;
            d_insn_b <= '0;
            x_a <= '0;
            x_b <= '0;
            m_a <= '0;
            m_b <= '0;
            w_a <= '0;
            w_b <= '0;
        end else begin
            pc <= pc_next;
            d_insn_a <= d_next_a;
            d_insn_b <= d_next_b;
            // bubbles go into X for a lane that does not issue
            x_a <= stall_a ? lc4_dec_t'('0) : d_a;
            x_b <= stall_b ? lc4_dec_t'('0) : d_b;
            m_a <= x_a;
            m_b <= x_b;
            w_a <= m_a;
            w_b <= m_b;
        end
    end

    always_ff @(posedge gwe) begin
        rs_x_a <= rs_d_a;
        rt_x_a <= rt_d_a;
        rs_x_b <= rs_d_b;
        rt_x_b <= rt_d_b;
        m_res_a <= alu_a;
        m_res_b <= alu_b;
        // forwarded rt becomes the store data carried into M
        mst_a <= rt_fwd_a;
        mst_b <= rt_fwd_b;
        w_res_a <= m_res_a;
        w_res_b <= m_res_b;
        w_ld_a <= i_dmem_data;
        w_ld_b <= i_dmem_data;
    end

    // single memory port, A goes first
    assign m_mem_a = m_a.is_load || m_a.is_store;
    assign m_mem_b = m_b.is_load || m_b.is_store;
    assign o_dmem_addr = m_mem_a ? m_res_a : (m_mem_b ? m_res_b : '0);
    assign o_dmem_we = m_a.is_store || m_b.is_store;
    assign o_dmem_towrite = m_a.is_store ? st_a : (m_b.is_store ? st_b : '0);

    // load data for loads, ALU result for everything else
    assign wb_a = w_a.is_load ? w_ld_a : w_res_a;
    assign wb_b = w_b.is_load ? w_ld_b : w_res_b;

    assign o_cur_pc = pc;
    assign o_wb_we_a = w_a.rd_we;
    assign o_wb_sel_a = w_a.rd;
    assign o_wb_data_a = wb_a;
    assign o_wb_we_b = w_b.rd_we;
    assign o_wb_sel_b = w_b.rd;
    assign o_wb_data_b = wb_b;

endmodule

// File: verilog/lc4_bypass.sv
`timescale 1ns/100ps

module lc4_bypass (
    input  lc4_pkg::lc4_dec_t           i_x_a,
    input  lc4_pkg::lc4_dec_t           i_x_b,
    input  lc4_pkg::lc4_dec_t           i_m_a,
    input  lc4_pkg::lc4_dec_t           i_m_b,
    input  lc4_pkg::lc4_dec_t           i_w_a,
    input  lc4_pkg::lc4_dec_t           i_w_b,
    input  logic [lc4_pkg::DATA_W-1:0] i_rs_x_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_rt_x_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_rs_x_b,
    input  logic [lc4_pkg::DATA_W-1:0] i_rt_x_b,
    input  logic [lc4_pkg::DATA_W-1:0] i_m_res_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_m_res_b,
    input  logic [lc4_pkg::DATA_W-1:0] i_wb_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_wb_b,
    input  logic [lc4_pkg::DATA_W-1:0] i_mst_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_mst_b,
    output logic [lc4_pkg::DATA_W-1:0] o_rs_a,
    output logic [lc4_pkg::DATA_W-1:0] o_rt_a,
    output logic [lc4_pkg::DATA_W-1:0] o_rs_b,
    output logic [lc4_pkg::DATA_W-1:0] o_rt_b,
    output logic [lc4_pkg::DATA_W-1:0] o_st_a,
    output logic [lc4_pkg::DATA_W-1:0] o_st_b
);
    import lc4_pkg::*;

    function automatic logic writes(input lc4_dec_t p, input logic [SEL_W-1:0] sel);
        return p.rd_we && p.rd == sel;
    endfunction

    // W stage only, B before A since B is younger
    function automatic logic [DATA_W-1:0] fwd_w(input logic [SEL_W-1:0] sel,
                                                input logic [DATA_W-1:0] own);
        logic [DATA_W-1:0] val;
        if (writes(i_w_b, sel)) begin
            val = i_wb_b;
        end else if (writes(i_w_a, sel)) begin
            val = i_wb_a;
        end else begin
            val = own;
        end
        return val;
    endfunction

    // MX then WX, youngest first
    // a load in M only holds its address so it is skipped here
    function automatic logic [DATA_W-1:0] fwd_x(input logic [SEL_W-1:0] sel,
                                                input logic [DATA_W-1:0] own);
        logic [DATA_W-1:0] val;
        if (writes(i_m_b, sel) && !i_m_b.is_load) begin
            val = i_m_res_b;
        end else if (writes(i_m_a, sel) && !i_m_a.is_load) begin
            val = i_m_res_a;
        end else begin
            val = fwd_w(sel, own);
        end
        return val;
    endfunction

    always_comb begin
        o_rs_a = fwd_x(i_x_a.rs, i_rs_x_a);
        o_rt_a = fwd_x(i_x_a.rt, i_rt_x_a);
        o_rs_b = fwd_x(i_x_b.rs, i_rs_x_b);
        o_rt_b = fwd_x(i_x_b.rt, i_rt_x_b);

        // WM store data, picks up a load that was still in M during X
        o_st_a = fwd_w(i_m_a.rt, i_mst_a);
        // MM from the paired A, which is newer than anything in W
        if (writes(i_m_a, i_m_b.rt)) begin
            o_st_b = i_m_res_a;
        end else begin
            o_st_b = fwd_w(i_m_b.rt, i_mst_b);
        end
    end

endmodule

// File: verilog/lc4_issue_ctrl.sv
`timescale 1ns/100ps

module lc4_issue_ctrl (
    input  lc4_pkg::lc4_dec_t i_d_a,
    input  lc4_pkg::lc4_dec_t i_d_b,
    input  lc4_pkg::lc4_dec_t i_x_a,
    input  lc4_pkg::lc4_dec_t i_x_b,
    output logic              o_switch,
    output logic              o_stall_a,
    output logic              o_stall_b
);
    import lc4_pkg::*;

    logic ltu_a;
    logic ltu_b;
    logic b_needs_a;
    logic mem_pair;

    // does the youngest X producer of sel happen to be a load
    function automatic logic load_hit(input logic [SEL_W-1:0] sel);
        logic hit;
        // x_b is younger and hides x_a when both write sel
        if (i_x_b.rd_we && i_x_b.rd == sel) begin
            hit = i_x_b.is_load;
        end else begin
            hit = i_x_a.rd_we && i_x_a.is_load && i_x_a.rd == sel;
        end
        return hit;
    endfunction

    // load-to-use for one decode slot
    function automatic logic load_use(input lc4_dec_t c);
        logic rs_hit;
        logic rt_hit;
        rs_hit = c.rs_re && load_hit(c.rs);
        // store data is not needed until M, the loaded word reaches it
        // from W there
        rt_hit = c.rt_re && !c.is_store && load_hit(c.rt);
        return rs_hit || rt_hit;
    endfunction

    always_comb begin
        ltu_a = load_use(i_d_a);
        ltu_b = load_use(i_d_b);

        // B reads what A writes in the same pair
        // a store of A's result is left alone, M-A covers that
        b_needs_a = i_d_a.rd_we &&
            ((i_d_b.rs_re && i_d_b.rs == i_d_a.rd) ||
             (i_d_b.rt_re && !i_d_b.is_store && i_d_b.rt == i_d_a.rd));

        // only one data memory port
        mem_pair = (i_d_a.is_load || i_d_a.is_store) &&
                   (i_d_b.is_load || i_d_b.is_store);

        // a stall of A holds the whole pair in D
        o_stall_a = ltu_a;

        // otherwise A issues alone and B slides over into A next cycle
        o_switch = !ltu_a && (b_needs_a || mem_pair || ltu_b);

        // B is not issued on either
        o_stall_b = ltu_a || o_switch;
    end

endmodule

// File: verilog/lc4_regfile_2w.sv
`timescale 1ns/100ps

module lc4_regfile_2w (
    input  logic                        gwe,
    input  logic                        i_arst_n,
    input  logic [lc4_pkg::SEL_W-1:0]  i_rs_sel_a,
    input  logic [lc4_pkg::SEL_W-1:0]  i_rt_sel_a,
    input  logic [lc4_pkg::SEL_W-1:0]  i_rs_sel_b,
    input  logic [lc4_pkg::SEL_W-1:0]  i_rt_sel_b,
    output logic [lc4_pkg::DATA_W-1:0] o_rs_data_a,
    output logic [lc4_pkg::DATA_W-1:0] o_rt_data_a,
    output logic [lc4_pkg::DATA_W-1:0] o_rs_data_b,
    output logic [lc4_pkg::DATA_W-1:0] o_rt_data_b,
    input  logic [lc4_pkg::SEL_W-1:0]  i_rd_sel_a,
    input  logic                        i_rd_we_a,
    input  logic [lc4_pkg::DATA_W-1:0] i_wdata_a,
    input  logic [lc4_pkg::SEL_W-1:0]  i_rd_sel_b,
    input  logic                        i_rd_we_b,
    input  logic [lc4_pkg::DATA_W-1:0] i_wdata_b
);
    import lc4_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_rd_we_a) begin
                regs[i_rd_sel_a] <= i_wdata_a;
            end
            // b is the younger insn, its update lands last on a collision
            if (i_rd_we_b) begin
                regs[i_rd_sel_b] <= i_wdata_b;
            end
        end
    end

    // write-through, b checked first to match the write priority
    function automatic logic [DATA_W-1:0] read_port(input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] val;
        if (i_rd_we_b && i_rd_sel_b == sel) begin
            val = i_wdata_b;
        end else if (i_rd_we_a && i_rd_sel_a == sel) begin
            val = i_wdata_a;
        end else begin
            val = regs[sel];
        end
        return val;
    endfunction

    always_comb begin
        o_rs_data_a = read_port(i_rs_sel_a);
        o_rt_data_a = read_port(i_rt_sel_a);
        o_rs_data_b = read_port(i_rs_sel_b);
        o_rt_data_b = read_port(i_rt_sel_b);
    end

endmodule

// File: verilog/lc4_alu.sv
`timescale 1ns/100ps

module lc4_alu (
    input  logic [lc4_pkg::DATA_W-1:0] i_insn,
    input  logic [lc4_pkg::DATA_W-1:0] i_rs_data,
    input  logic [lc4_pkg::DATA_W-1:0] i_rt_data,
    output logic [lc4_pkg::DATA_W-1:0] o_result
);
    import lc4_pkg::*;

    logic [DATA_W-1:0] imm5;
    logic [DATA_W-1:0] imm6;
    logic [DATA_W-1:0] imm9;

    // sign-extended immediates
    assign imm5 = {{(DATA_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(DATA_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(DATA_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_insn[15:12])
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else if (i_insn[5:3] == SUB_SUB) begin
                    o_result = i_rs_data - i_rt_data;
                end else begin
                    o_result = i_rs_data + i_rt_data;
                end
            end
            OP_LOGIC: o_result = i_insn[5] ? (i_rs_data & imm5) : (i_rs_data & i_rt_data);
            OP_CONST: o_result = imm9;
            // effective address for both memory ops
            OP_LDR, OP_STR: o_result = i_rs_data + imm6;
            default: o_result = '0;
        endcase
    end

endmodule

// File: verilog/lc4_decoder.sv
`timescale 1ns/100ps

module lc4_decoder (
    input  logic [lc4_pkg::DATA_W-1:0] i_insn,
    output lc4_pkg::lc4_dec_t          o_dec
);
    import lc4_pkg::*;

    logic [3:0] opcode;
    logic [2:0] sub_op;
    logic       imm_form;

    assign opcode = i_insn[15:12];
    assign sub_op = i_insn[5:3];
    // imm5 variants of ADD and AND
    assign imm_form = i_insn[5];

    always_comb begin
        o_dec = '0;
        o_dec.insn = i_insn;
        // field positions shared by all kept formats
        o_dec.rd = i_insn[11:9];
        o_dec.rs = i_insn[8:6];
        o_dec.rt = i_insn[2:0];
        case (opcode)
            OP_ARITH: begin
                if (imm_form) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rd_we = 1'b1;
                end else if (sub_op == SUB_ADD || sub_op == SUB_SUB) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rt_re = 1'b1;
                    o_dec.rd_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                if (imm_form) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rd_we = 1'b1;
                end else if (sub_op == SUB_AND) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rt_re = 1'b1;
                    o_dec.rd_we = 1'b1;
                end
            end
            OP_CONST: begin
                o_dec.rd_we = 1'b1;
            end
            OP_LDR: begin
                o_dec.rs_re = 1'b1;
                o_dec.rd_we = 1'b1;
                o_dec.is_load = 1'b1;
            end
            OP_STR: begin
                // store data register sits in the rd field
                o_dec.rt = i_insn[11:9];
                o_dec.rs_re = 1'b1;
                o_dec.rt_re = 1'b1;
                o_dec.is_store = 1'b1;
            end
            // MUL, DIV, branches and the rest fall through as no-ops
            default: ;
        endcase
    end

endmodule

// File: verilog/lc4_pkg.sv
package lc4_pkg;

    // datapath word width
    localparam int DATA_W = 16;
    // register select width and register count
    localparam int SEL_W = 3;
    localparam int NUM_REGS = 8;

    // first fetch address after reset, start of user code
    localparam logic [DATA_W-1:0] PC_RESET = 16'h8200;

    // primary opcodes in insn[15:12]
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_CONST = 4'b1001;
    localparam logic [3:0] OP_LDR = 4'b0110;
    localparam logic [3:0] OP_STR = 4'b0111;

    // register-form sub-ops in insn[5:3]
    // insn[5] set selects the imm5 form of ADD and AND instead
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;

    // decoded instruction, carried down each pipe from D to W
    // an all-zero value is a bubble
    typedef struct packed {
        // first source, also the load/store base
        logic [SEL_W-1:0] rs;
        // second source, the data register of a store
        logic [SEL_W-1:0] rt;
        // destination
        logic [SEL_W-1:0] rd;
        // source read enables
        logic rs_re;
        logic rt_re;
        // register file write
        logic rd_we;
        // memory ops, at most one of the two per pair reaches M
        logic is_load;
        logic is_store;
        // raw bits, the ALU decodes its own operation from these
        logic [DATA_W-1:0] insn;
    } lc4_dec_t;

endpackage
